// ==== design/rvv_alu_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rvv alu constants
// vector length, rob index and vstart widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RVV_ALU_CONSTS_SVH
`define RVV_ALU_CONSTS_SVH

// vector register length in bits, 64 or 128
`define VLEN 64

// rob entry index width
`define ROB_DEPTH_WIDTH 4

// vstart must be able to hold VLEN itself
`define VSTART_WIDTH ($clog2(`VLEN) + 1)

`endif

// ==== design/rvv_alu_issue_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rvv alu issue stage
// takes uops from the alu reservation station,
// decodes and checks them, registers the result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "rvv_alu_consts.svh"

module rvv_alu_issue_stage
  import rvv_alu_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        uop_valid,
  output logic                        uop_ready,
  input  logic [`ROB_DEPTH_WIDTH-1:0] rob_entry,
  input  exe_funct3_e                 uop_funct3,
  input  logic [5:0]                  uop_funct6,
  input  logic [`VSTART_WIDTH-1:0]    vstart,
  input  logic                        vm,
  input  logic [`VLEN-1:0]            vd_data,
  input  logic                        vd_data_valid,
  input  logic [`VLEN-1:0]            vs1_data,
  input  logic                        vs1_data_valid,
  input  logic [`VLEN-1:0]            vs2_data,
  input  logic                        vs2_data_valid,
  output logic                        iss_valid,
  input  logic                        iss_ready,
  output logic [`ROB_DEPTH_WIDTH-1:0] iss_rob_entry,
  output mask_op_e                    iss_op,
  output logic                        iss_legal,
  output logic [`VSTART_WIDTH-1:0]    iss_vstart,
  output logic [`VLEN-1:0]            iss_vs1,
  output logic [`VLEN-1:0]            iss_vs2,
  output logic [`VLEN-1:0]            iss_vd
);

  // upper funct6 bits shared by all mask logical ops
  localparam logic [2:0] mask_funct6_hi = 3'b011;

  logic     funct3_ok;
  logic     funct6_ok;
  logic     operands_ok;
  logic     dec_legal;
  mask_op_e dec_op;
  logic     load;

  // decode
  assign funct3_ok   = (uop_funct3 == OPMVV) || (uop_funct3 == OPMVX);
  assign funct6_ok   = (uop_funct6[5:3] == mask_funct6_hi);
  assign operands_ok = vd_data_valid && vs1_data_valid && vs2_data_valid;
  assign dec_legal   = funct3_ok && funct6_ok && operands_ok && vm;
  assign dec_op      = mask_op_e'(uop_funct6[2:0]);

  // one-entry register, free when empty or draining
  assign uop_ready = !iss_valid || iss_ready;
  assign load      = uop_valid && uop_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      iss_valid <= 1'b0;
    end else if (load) begin
      iss_valid <= 1'b1;
    end else if (iss_ready) begin
      iss_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      iss_rob_entry <= rob_entry;
      iss_op        <= dec_op;
      iss_legal     <= dec_legal;
      iss_vstart    <= vstart;
      iss_vs1       <= vs1_data;
      iss_vs2       <= vs2_data;
      iss_vd        <= vd_data;
    end
  end

endmodule

// ==== design/rvv_alu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rvv alu package
// funct3 categories and decoded mask-logic opcodes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rvv_alu_pkg;

  // rvv funct3 categories, standard encodings
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } exe_funct3_e;

  // mask logical ops, funct6 011000 to 011111
  // encoding is funct6[2:0]
  typedef enum logic [2:0] {
    VMANDN = 3'b000,
    VMAND  = 3'b001,
    VMOR   = 3'b010,
    VMXOR  = 3'b011,
    VMORN  = 3'b100,
    VMNAND = 3'b101,
    VMNOR  = 3'b110,
    VMXNOR = 3'b111
  } mask_op_e;

endpackage

// ==== design/rvv_alu_rob_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rvv alu writeback stage
// two-entry buffer between the pipe and the rob
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "rvv_alu_consts.svh"

module rvv_alu_rob_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        exe_valid,
  output logic                        exe_ready,
  input  logic [`ROB_DEPTH_WIDTH-1:0] exe_rob_entry,
  input  logic [`VLEN-1:0]            exe_w_data,
  input  logic                        exe_w_valid,
  output logic                        result_valid,
  input  logic                        result_ready,
  output logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry,
  output logic [`VLEN-1:0]            result_w_data,
  output logic                        result_w_valid
);

  logic [`ROB_DEPTH_WIDTH-1:0] rob_mem [2];
  logic [`VLEN-1:0]            data_mem [2];
  logic                        wvalid_mem [2];

  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  // upstream ready looks only at occupancy
  assign exe_ready    = (count != 2'd2);
  assign result_valid = (count != 2'd0);

  assign push = exe_valid && exe_ready;
  assign pop  = result_valid && result_ready;

  // oldest entry is always on the output
  assign result_rob_entry = rob_mem[rd_ptr];
  assign result_w_data    = data_mem[rd_ptr];
  assign result_w_valid   = wvalid_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      rob_mem[wr_ptr]    <= exe_rob_entry;
      data_mem[wr_ptr]   <= exe_w_data;
      wvalid_mem[wr_ptr] <= exe_w_valid;
    end
  end

endmodule

// ==== design/rvv_alu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rvv alu mask-logic pipe
// issue, execute and writeback stages in a chain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "rvv_alu_consts.svh"

module rvv_alu_top
  import rvv_alu_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        uop_valid,
  output logic                        uop_ready,
  input  logic [`ROB_DEPTH_WIDTH-1:0] rob_entry,
  input  exe_funct3_e                 uop_funct3,
  input  logic [5:0]                  uop_funct6,
  input  logic [`VSTART_WIDTH-1:0]    vstart,
  input  logic                        vm,
  input  logic [`VLEN-1:0]            vd_data,
  input  logic                        vd_data_valid,
  input  logic [`VLEN-1:0]            vs1_data,
  input  logic                        vs1_data_valid,
  input  logic [`VLEN-1:0]            vs2_data,
  input  logic                        vs2_data_valid,
  output logic                        result_valid,
  input  logic                        result_ready,
  output logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry,
  output logic [`VLEN-1:0]            result_w_data,
  output logic                        result_w_valid
);

  // issue to execute
  logic                        iss_valid;
  logic                        iss_ready;
  logic [`ROB_DEPTH_WIDTH-1:0] iss_rob_entry;
  mask_op_e                    iss_op;
  logic                        iss_legal;
  logic [`VSTART_WIDTH-1:0]    iss_vstart;
  logic [`VLEN-1:0]            iss_vs1;
  logic [`VLEN-1:0]            iss_vs2;
  logic [`VLEN-1:0]            iss_vd;

  // execute to writeback
  logic                        exe_valid;
  logic                        exe_ready;
  logic [`ROB_DEPTH_WIDTH-1:0] exe_rob_entry;
  logic [`VLEN-1:0]            exe_w_data;
  logic                        exe_w_valid;

  rvv_alu_issue_stage u_issue (
    .clk            (clk),
    .reset          (reset),
    .uop_valid      (uop_valid),
    .uop_ready      (uop_ready),
    .rob_entry      (rob_entry),
    .uop_funct3     (uop_funct3),
    .uop_funct6     (uop_funct6),
    .vstart         (vstart),
    .vm             (vm),
    .vd_data        (vd_data),
    .vd_data_valid  (vd_data_valid),
    .vs1_data       (vs1_data),
    .vs1_data_valid (vs1_data_valid),
    .vs2_data       (vs2_data),
    .vs2_data_valid (vs2_data_valid),
    .iss_valid      (iss_valid),
    .iss_ready      (iss_ready),
    .iss_rob_entry  (iss_rob_entry),
    .iss_op         (iss_op),
    .iss_legal      (iss_legal),
    .iss_vstart     (iss_vstart),
    .iss_vs1        (iss_vs1),
    .iss_vs2        (iss_vs2),
    .iss_vd         (iss_vd)
  );

  rvv_alu_unit u_unit (
    .clk           (clk),
    .reset         (reset),
    .iss_valid     (iss_valid),
    .iss_ready     (iss_ready),
    .iss_rob_entry (iss_rob_entry),
    .iss_op        (iss_op),
    .iss_legal     (iss_legal),
    .iss_vstart    (iss_vstart),
    .iss_vs1       (iss_vs1),
    .iss_vs2       (iss_vs2),
    .iss_vd        (iss_vd),
    .exe_valid     (exe_valid),
    .exe_ready     (exe_ready),
    .exe_rob_entry (exe_rob_entry),
    .exe_w_data    (exe_w_data),
    .exe_w_valid   (exe_w_valid)
  );

  rvv_alu_rob_stage u_rob (
    .clk              (clk),
    .reset            (reset),
    .exe_valid        (exe_valid),
    .exe_ready        (exe_ready),
    .exe_rob_entry    (exe_rob_entry),
    .exe_w_data       (exe_w_data),
    .exe_w_valid      (exe_w_valid),
    .result_valid     (result_valid),
    .result_ready     (result_ready),
    .result_rob_entry (result_rob_entry),
    .result_w_data    (result_w_data),
    .result_w_valid   (result_w_valid)
  );

endmodule

// ==== design/rvv_alu_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rvv alu execute stage
// mask logical ops with prestart merge from vd
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "rvv_alu_consts.svh"

module rvv_alu_unit
  import rvv_alu_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        iss_valid,
  output logic                        iss_ready,
  input  logic [`ROB_DEPTH_WIDTH-1:0] iss_rob_entry,
  input  mask_op_e                    iss_op,
  input  logic                        iss_legal,
  input  logic [`VSTART_WIDTH-1:0]    iss_vstart,
  input  logic [`VLEN-1:0]            iss_vs1,
  input  logic [`VLEN-1:0]            iss_vs2,
  input  logic [`VLEN-1:0]            iss_vd,
  output logic                        exe_valid,
  input  logic                        exe_ready,
  output logic [`ROB_DEPTH_WIDTH-1:0] exe_rob_entry,
  output logic [`VLEN-1:0]            exe_w_data,
  output logic                        exe_w_valid
);

  logic [`VLEN-1:0] logic_result;
  logic [`VLEN-1:0] prestart_mask;
  logic [`VLEN-1:0] merged_data;
  logic             load;

  function automatic logic [`VLEN-1:0] f_vmandn(logic [`VLEN-1:0] vs2, logic [`VLEN-1:0] vs1);
    return vs2 & ~vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmand(logic [`VLEN-1:0] vs2, logic [`VLEN-1:0] vs1);
    return vs2 & vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmor(logic [`VLEN-1:0] vs2, logic [`VLEN-1:0] vs1);
    return vs2 | vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmxor(logic [`VLEN-1:0] vs2, logic [`VLEN-1:0] vs1);
    return vs2 ^ vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmorn(logic [`VLEN-1:0] vs2, logic [`VLEN-1:0] vs1);
    return vs2 | ~vs1;
  endfunction

  function automatic logic [`VLEN-1:0] f_vmnand(logic [`VLEN-1:0] vs2, logic [`VLEN-1:0] vs1);
    return ~(vs2 & vs1);
  endfunction

  function automatic logic [`VLEN-1:0] f_vmnor(logic [`VLEN-1:0] vs2, logic [`VLEN-1:0] vs1);
    return ~(vs2 | vs1);
  endfunction

  function automatic logic [`VLEN-1:0] f_vmxnor(logic [`VLEN-1:0] vs2, logic [`VLEN-1:0] vs1);
    return ~(vs2 ^ vs1);
  endfunction

  always_comb begin
    case (iss_op)
      VMANDN:  logic_result = f_vmandn(iss_vs2, iss_vs1);
      VMAND:   logic_result = f_vmand(iss_vs2, iss_vs1);
      VMOR:    logic_result = f_vmor(iss_vs2, iss_vs1);
      VMXOR:   logic_result = f_vmxor(iss_vs2, iss_vs1);
      VMORN:   logic_result = f_vmorn(iss_vs2, iss_vs1);
      VMNAND:  logic_result = f_vmnand(iss_vs2, iss_vs1);
      VMNOR:   logic_result = f_vmnor(iss_vs2, iss_vs1);
      default: logic_result = f_vmxnor(iss_vs2, iss_vs1);
    endcase
  end

  // bits below vstart keep vd, vstart >= VLEN keeps all of it
  always_comb begin
    for (int i = 0; i < `VLEN; i++) begin
      prestart_mask[i] = (i < int'(iss_vstart));
    end
  end

  assign merged_data = (iss_vd & prestart_mask) | (logic_result & ~prestart_mask);

  assign iss_ready = !exe_valid || exe_ready;
  assign load      = iss_valid && iss_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      exe_valid <= 1'b0;
    end else if (load) begin
      exe_valid <= 1'b1;
    end else if (exe_ready) begin
      exe_valid <= 1'b0;
    end
  end

  // illegal uops retire with zero data
  always_ff @(posedge clk) begin
    if (load) begin
      exe_rob_entry <= iss_rob_entry;
      exe_w_data    <= iss_legal ? merged_data : '0;
      exe_w_valid   <= iss_legal;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the rvv alu testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
  -f rvv_alu.f --top-module rvv_alu_tb -o rvv_alu_sim

# the simulation exits non-zero on $fatal, the log decides
./obj_dir/rvv_alu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q 'All tests passed!' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== rvv_alu.f ====
+incdir+design
design/rvv_alu_pkg.sv
design/rvv_alu_issue_stage.sv
design/rvv_alu_unit.sv
design/rvv_alu_rob_stage.sv
design/rvv_alu_top.sv
test/rvv_alu_tb.sv

// ==== test/rvv_alu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rvv alu testbench
// random mask-logic uops against a bit-level
// reference model, checked at the rob port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "rvv_alu_consts.svh"

module rvv_alu_tb
  import rvv_alu_pkg::*;
();

  localparam int         timeout_cycles = 200;
  // accepting edge, then issue and execute registers fill the buffer
  localparam int         exp_latency    = 2;
  localparam logic [2:0] mask_funct6_hi = 3'b011;

  typedef logic [`VLEN-1:0]             vec_t;
  typedef logic [`VSTART_WIDTH-1:0]     vstart_t;
  typedef logic [`ROB_DEPTH_WIDTH-1:0]  rob_t;

  typedef struct packed {
    rob_t rob;
    logic wvalid;
    vec_t data;
  } exp_t;

  logic        clk;
  logic        reset;
  logic        uop_valid;
  logic        uop_ready;
  rob_t        rob_entry;
  exe_funct3_e uop_funct3;
  logic [5:0]  uop_funct6;
  vstart_t     vstart;
  logic        vm;
  vec_t        vd_data;
  logic        vd_data_valid;
  vec_t        vs1_data;
  logic        vs1_data_valid;
  vec_t        vs2_data;
  logic        vs2_data_valid;
  logic        result_valid;
  logic        result_ready;
  rob_t        result_rob_entry;
  vec_t        result_w_data;
  logic        result_w_valid;

  integer seed = 32'he3ee87f7;
  string  test_name = "reset";
  logic   random_ready = 1'b0;
  int     uop_count = 0;
  exp_t   exp_q[$];
  exp_t   head = '0;
  logic   head_present = 1'b0;

  rvv_alu_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic fail_value(string what, vec_t exp, vec_t act);
    $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    stop_on_failure();
  endtask

  task automatic fail_plain(string what);
    $display("Error in %s: %s", test_name, what);
    stop_on_failure();
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    v = '0;
    for (int i = 0; i < `VLEN; i += 32) begin
      v = {v[`VLEN-33:0], rand_word()};
    end
    return v;
  endfunction

  // output bit indexed by {vs2, vs1}
  function automatic logic [3:0] truth_table(logic [2:0] op);
    case (op)
      3'd0: return 4'b0100;
      3'd1: return 4'b1000;
      3'd2: return 4'b1110;
      3'd3: return 4'b0110;
      3'd4: return 4'b1101;
      3'd5: return 4'b0111;
      3'd6: return 4'b0001;
      3'd7: return 4'b1001;
    endcase
  endfunction

  function automatic exp_t model_result();
    exp_t       r;
    logic [3:0] tt;
    r.rob    = rob_entry;
    r.wvalid = ((uop_funct3 == OPMVV) || (uop_funct3 == OPMVX)) &&
               (uop_funct6[5:3] == mask_funct6_hi) && vm &&
               vd_data_valid && vs1_data_valid && vs2_data_valid;
    r.data   = '0;
    tt       = truth_table(uop_funct6[2:0]);
    if (r.wvalid) begin
      for (int i = 0; i < `VLEN; i++) begin
        r.data[i] = (i < int'(vstart)) ? vd_data[i] : tt[{vs2_data[i], vs1_data[i]}];
      end
    end
    return r;
  endfunction

  // inputs are stable at the falling edge, so the coming transfers are known
  always @(negedge clk) begin
    if (reset) begin
      head_present = 1'b0;
    end else begin
      head_present = (exp_q.size() != 0);
      if (head_present) begin
        head = exp_q[0];
      end
      if (result_valid && result_ready && head_present) begin
        void'(exp_q.pop_front());
      end
      if (uop_valid && uop_ready) begin
        exp_q.push_back(model_result());
      end
    end
  end

  a_reset_quiet: assert property (@(negedge clk) reset |-> !result_valid)
    else fail_plain("result_valid was high while reset was asserted");

  a_expected: assert property (@(posedge clk) disable iff (reset)
      (result_valid && result_ready) |-> head_present)
    else fail_plain("a result came out with no uop outstanding");

  a_rob_entry: assert property (@(posedge clk) disable iff (reset)
      (result_valid && result_ready && head_present) |-> (result_rob_entry == head.rob))
    else fail_value("rob_entry", vec_t'(head.rob), vec_t'($sampled(result_rob_entry)));

  a_w_valid: assert property (@(posedge clk) disable iff (reset)
      (result_valid && result_ready && head_present) |-> (result_w_valid == head.wvalid))
    else fail_value("w_valid", vec_t'(head.wvalid), vec_t'($sampled(result_w_valid)));

  a_w_data: assert property (@(posedge clk) disable iff (reset)
      (result_valid && result_ready && head_present) |-> (result_w_data == head.data))
    else fail_value("w_data", head.data, $sampled(result_w_data));

  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk);
    #1;
    r = rand_word();
    if (random_ready) begin
      result_ready = r[0];
    end
  endtask

  // legal uop with fresh operands
  task automatic set_uop(mask_op_e op, exe_funct3_e f3, vstart_t vs);
    uop_count++;
    rob_entry      = rob_t'(uop_count);
    uop_funct3     = f3;
    uop_funct6     = {mask_funct6_hi, op};
    vstart         = vs;
    vm             = 1'b1;
    vd_data_valid  = 1'b1;
    vs1_data_valid = 1'b1;
    vs2_data_valid = 1'b1;
    vd_data        = rand_vec();
    vs1_data       = rand_vec();
    vs2_data       = rand_vec();
  endtask

  task automatic issue_uop();
    int waited;
    waited    = 0;
    uop_valid = 1'b1;
    while (!uop_ready && waited < timeout_cycles) begin
      next_cycle();
      waited++;
    end
    if (!uop_ready) begin
      fail_plain("uop_ready stayed low and the uop was never accepted");
    end
    next_cycle();
    uop_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < timeout_cycles) begin
      next_cycle();
      waited++;
    end
    if (exp_q.size() != 0) begin
      fail_plain("results still outstanding after the timeout");
    end
  endtask

  initial begin
    int          edges;
    logic [31:0] r;
    vstart_t     vs;
    reset          = 1'b1;
    uop_valid      = 1'b0;
    rob_entry      = '0;
    uop_funct3     = OPMVV;
    uop_funct6     = '0;
    vstart         = '0;
    vm             = 1'b0;
    vd_data        = '0;
    vd_data_valid  = 1'b0;
    vs1_data       = '0;
    vs1_data_valid = 1'b0;
    vs2_data       = '0;
    vs2_data_valid = 1'b0;
    result_ready   = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (uop_ready) else fail_plain("uop_ready was low in the first cycle after reset");

    test_name = "every_op";
    for (int f = 0; f < 2; f++) begin
      for (int op = 0; op < 8; op++) begin
        set_uop(mask_op_e'(op), (f == 0) ? OPMVV : OPMVX, '0);
        issue_uop();
      end
    end
    drain();

    test_name = "prestart";
    for (int k = 0; k < 12; k++) begin
      r = rand_word();
      case (k)
        0:       vs = '0;
        1:       vs = vstart_t'(1);
        2:       vs = vstart_t'(`VLEN - 1);
        3:       vs = vstart_t'(`VLEN);
        default: vs = vstart_t'(r % (`VLEN + 1));
      endcase
      set_uop(mask_op_e'(r[2:0]), OPMVV, vs);
      issue_uop();
    end
    drain();

    test_name = "illegal";
    for (int k = 0; k < 6; k++) begin
      set_uop(VMOR, OPMVX, vstart_t'(3));
      case (k)
        0:       uop_funct3 = OPIVV;
        1:       uop_funct6 = 6'b100101;
        2:       vm = 1'b0;
        3:       vd_data_valid = 1'b0;
        4:       vs1_data_valid = 1'b0;
        default: vs2_data_valid = 1'b0;
      endcase
      issue_uop();
    end
    drain();

    test_name = "latency";
    set_uop(VMXOR, OPMVV, '0);
    issue_uop();
    edges = 0;
    while (!result_valid && edges < timeout_cycles) begin
      next_cycle();
      edges++;
    end
    if (!result_valid) begin
      fail_plain("result_valid never rose after the uop was accepted");
    end
    assert (edges == exp_latency) else fail_value("latency", vec_t'(exp_latency), vec_t'(edges));
    drain();

    test_name = "backpressure";
    random_ready = 1'b1;
    for (int k = 0; k < 40; k++) begin
      r = rand_word();
      set_uop(mask_op_e'(r[2:0]), r[3] ? OPMVX : OPMVV, vstart_t'(r[31:8] % (`VLEN + 1)));
      vm = (r[7:4] != 4'd0);
      issue_uop();
    end
    drain();
    random_ready = 1'b0;
    result_ready = 1'b1;

    // every uop has retired, so a duplicate would still sit at the rob port
    if (result_valid) begin
      fail_plain("an extra result was waiting after every uop had retired");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule
